/* src/ed_alu_pkg.sv */
package ed_alu_pkg;

	// Field of the prime 2^255 - 19
	localparam int FIELD_W = 255;
	typedef logic [FIELD_W-1:0] field_t;

	localparam field_t P_MODULUS = {{(FIELD_W-5){1'b1}}, 5'b01101};
	localparam logic [4:0] FOLD_K = 5'd19; // 2^255 is 19 mod p

	typedef logic op_t;
	localparam op_t OP_DOUBLE = 1'b0;
	localparam op_t OP_SCALE = 1'b1;

	typedef logic [1:0] alu_state_t;
	localparam alu_state_t ST_IDLE = 2'd0;
	localparam alu_state_t ST_DOUBLE = 2'd1;
	localparam alu_state_t ST_SCALE = 2'd2;

	localparam int STEP_W = 4;
	typedef logic [STEP_W-1:0] step_t;
	localparam step_t DOUBLE_LAST = 4'd10;
	localparam step_t SCALE_LAST = 4'd2;

	localparam int REG_IDX_W = 3;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	localparam reg_idx_t REG_X = 3'd0;
	localparam reg_idx_t REG_Y = 3'd1;
	localparam reg_idx_t REG_Z = 3'd2;
	localparam reg_idx_t REG_T = 3'd3;
	localparam reg_idx_t REG_W = 3'd4; // Scratch
	localparam reg_idx_t REG_R = 3'd5; // Scale factor

endpackage

/* src/alu_fsm.sv */
`timescale 1ns/1ps

module alu_fsm (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  ed_alu_pkg::op_t        op,
	input  logic                   keep,
	input  logic                   last,
	output ed_alu_pkg::alu_state_t state,
	output logic                   busy,
	output logic                   ready
);
	import ed_alu_pkg::*;

	alu_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (start) begin
					case (op)
						OP_DOUBLE: state_nxt = ST_DOUBLE;
						OP_SCALE:  state_nxt = ST_SCALE;
						default:   state_nxt = ST_IDLE;
					endcase
				end
			end
			ST_DOUBLE: begin
				if (last && !keep) begin
					state_nxt = ST_IDLE; // Keep chains the next doubling
				end
			end
			ST_SCALE: begin
				if (last) begin
					state_nxt = ST_IDLE;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign busy = (state != ST_IDLE);
	assign ready = last && (state != ST_IDLE); // One pulse per operation

endmodule

/* src/step_counter.sv */
`timescale 1ns/1ps

module step_counter (
	input  logic                   clk,
	input  logic                   rst,
	input  ed_alu_pkg::alu_state_t state,
	output ed_alu_pkg::step_t      step,
	output logic                   last
);
	import ed_alu_pkg::*;

	always_comb begin
		case (state)
			ST_DOUBLE: last = (step == DOUBLE_LAST);
			ST_SCALE:  last = (step == SCALE_LAST);
			default:   last = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			step <= '0;
		end else if (state == ST_IDLE || last) begin
			step <= '0; // Ready for the next operation
		end else begin
			step <= step + step_t'(1);
		end
	end

endmodule

/* src/operand_select.sv */
`timescale 1ns/1ps

module operand_select (
	input  ed_alu_pkg::alu_state_t state,
	input  ed_alu_pkg::step_t      step,
	input  ed_alu_pkg::field_t     x,
	input  ed_alu_pkg::field_t     y,
	input  ed_alu_pkg::field_t     z,
	input  ed_alu_pkg::field_t     t,
	input  ed_alu_pkg::field_t     w,
	input  ed_alu_pkg::field_t     r,
	input  ed_alu_pkg::field_t     mul_res,
	output ed_alu_pkg::field_t     mul_a,
	output ed_alu_pkg::field_t     mul_b,
	output ed_alu_pkg::field_t     add_a,
	output ed_alu_pkg::field_t     add_b,
	output ed_alu_pkg::field_t     sub_a,
	output ed_alu_pkg::field_t     sub_b
);
	import ed_alu_pkg::*;

	always_comb begin
		mul_a = '0;
		mul_b = '0;
		add_a = '0;
		add_b = '0;
		sub_a = '0;
		sub_b = '0;
		if (state == ST_DOUBLE) begin
			case (step)
				4'd0: begin
					mul_a = x; // A = X^2
					mul_b = x;
				end
				4'd1: begin
					mul_a = y; // B = Y^2
					mul_b = y;
					add_a = x;
					add_b = y;
				end
				4'd2: begin
					mul_a = z;
					mul_b = z;
					add_a = mul_res; // S = B + A
					add_b = t;
					sub_a = mul_res; // G = B - A
					sub_b = t;
				end
				4'd3: begin
					mul_a = x; // (X+Y)^2
					mul_b = x;
					add_a = mul_res; // 2Z^2
					add_b = mul_res;
				end
				4'd4: begin
					sub_a = mul_res; // E
					sub_b = t;
				end
				4'd5: begin
					sub_a = y; // F = G - 2Z^2
					sub_b = z;
				end
				4'd6: begin
					mul_a = y; // G*S
					mul_b = t;
				end
				4'd7: begin
					mul_a = x; // E*S
					mul_b = t;
				end
				4'd8: begin
					mul_a = x; // E*F
					mul_b = z;
					sub_b = mul_res;
				end
				4'd9: begin
					mul_a = z; // F*G
					mul_b = y;
					sub_b = w;
				end
				default: ;
			endcase
		end else if (state == ST_SCALE) begin
			case (step)
				4'd0: begin
					mul_a = x;
					mul_b = r;
				end
				4'd1: begin
					mul_a = y;
					mul_b = r;
					sub_b = mul_res; // Negated X product
				end
				4'd2: sub_b = mul_res;
				default: ;
			endcase
		end
	end

endmodule

/* src/field_datapath.sv */
`timescale 1ns/1ps

module field_datapath (
	input  logic               clk,
	input  logic               rst,
	input  ed_alu_pkg::field_t mul_a,
	input  ed_alu_pkg::field_t mul_b,
	input  ed_alu_pkg::field_t add_a,
	input  ed_alu_pkg::field_t add_b,
	input  ed_alu_pkg::field_t sub_a,
	input  ed_alu_pkg::field_t sub_b,
	output ed_alu_pkg::field_t mul_res,
	output ed_alu_pkg::field_t sum,
	output ed_alu_pkg::field_t diff
);
	import ed_alu_pkg::*;

	logic [2*FIELD_W-1:0] prod_r;
	logic [FIELD_W+5:0] fold1;
	logic [FIELD_W:0] fold2;
	logic [FIELD_W:0] add_ext;
	logic [FIELD_W:0] sub_ext;

	always_ff @(posedge clk) begin
		if (rst) begin
			prod_r <= '0;
		end else begin
			prod_r <= (2*FIELD_W)'(mul_a) * (2*FIELD_W)'(mul_b); // Full product
		end
	end

	// Fold the upper half down twice, then one conditional subtract
	assign fold1 = (FIELD_W+6)'(prod_r[FIELD_W-1:0])
		+ (FIELD_W+6)'(prod_r[2*FIELD_W-1:FIELD_W]) * (FIELD_W+6)'(FOLD_K);
	assign fold2 = {1'b0, fold1[FIELD_W-1:0]}
		+ (FIELD_W+1)'(fold1[FIELD_W+5:FIELD_W]) * (FIELD_W+1)'(FOLD_K);
	assign mul_res = (fold2 >= {1'b0, P_MODULUS}) ?
		FIELD_W'(fold2 - {1'b0, P_MODULUS}) : fold2[FIELD_W-1:0];

	assign add_ext = {1'b0, add_a} + {1'b0, add_b};
	assign sum = (add_ext >= {1'b0, P_MODULUS}) ?
		FIELD_W'(add_ext - {1'b0, P_MODULUS}) : add_ext[FIELD_W-1:0];

	assign sub_ext = {1'b0, sub_a} - {1'b0, sub_b}; // Top bit is the borrow
	assign diff = sub_ext[FIELD_W] ?
		FIELD_W'(sub_ext + {1'b0, P_MODULUS}) : sub_ext[FIELD_W-1:0];

endmodule

/* src/writeback_route.sv */
`timescale 1ns/1ps

module writeback_route (
	input  ed_alu_pkg::alu_state_t state,
	input  ed_alu_pkg::step_t      step,
	input  ed_alu_pkg::field_t     mul_res,
	input  ed_alu_pkg::field_t     sum,
	input  ed_alu_pkg::field_t     diff,
	input  ed_alu_pkg::field_t     w,
	output logic                   x_we,
	output logic                   y_we,
	output logic                   z_we,
	output logic                   t_we,
	output logic                   w_we,
	output ed_alu_pkg::field_t     x_d,
	output ed_alu_pkg::field_t     y_d,
	output ed_alu_pkg::field_t     z_d,
	output ed_alu_pkg::field_t     t_d,
	output ed_alu_pkg::field_t     w_d
);
	import ed_alu_pkg::*;

	field_t even_res;

	// p is odd, so p minus an odd product is even
	assign even_res = mul_res[0] ? diff : mul_res;

	always_comb begin
		{x_we, y_we, z_we, t_we, w_we} = '0;
		x_d = '0;
		y_d = '0;
		z_d = '0;
		t_d = '0;
		w_d = '0;
		if (state == ST_DOUBLE) begin
			case (step)
				4'd1: begin
					{t_we, t_d} = {1'b1, mul_res}; // T holds A
					{x_we, x_d} = {1'b1, sum}; // X holds X+Y
				end
				4'd2: begin
					{y_we, y_d} = {1'b1, diff}; // G
					{t_we, t_d} = {1'b1, sum}; // S
				end
				4'd3: {z_we, z_d} = {1'b1, sum}; // 2Z^2
				4'd4: {x_we, x_d} = {1'b1, diff}; // E
				4'd5: {z_we, z_d} = {1'b1, diff}; // F
				4'd7: {w_we, w_d} = {1'b1, mul_res}; // G*S
				4'd8: {t_we, t_d} = {1'b1, diff}; // T3
				4'd9: begin
					{x_we, x_d} = {1'b1, mul_res}; // X3
					{w_we, w_d} = {1'b1, diff}; // Y3 parked in W
				end
				4'd10: begin
					{z_we, z_d} = {1'b1, mul_res}; // Z3
					{y_we, y_d} = {1'b1, w};
				end
				default: ;
			endcase
		end else if (state == ST_SCALE) begin
			case (step)
				4'd1: {x_we, x_d} = {1'b1, even_res};
				4'd2: {y_we, y_d} = {1'b1, even_res};
				default: ;
			endcase
		end
	end

endmodule

/* src/point_regfile.sv */
`timescale 1ns/1ps

module point_regfile (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 load_en,
	input  ed_alu_pkg::reg_idx_t load_sel,
	input  ed_alu_pkg::field_t   load_data,
	input  logic                 x_we,
	input  logic                 y_we,
	input  logic                 z_we,
	input  logic                 t_we,
	input  logic                 w_we,
	input  ed_alu_pkg::field_t   x_d,
	input  ed_alu_pkg::field_t   y_d,
	input  ed_alu_pkg::field_t   z_d,
	input  ed_alu_pkg::field_t   t_d,
	input  ed_alu_pkg::field_t   w_d,
	input  ed_alu_pkg::reg_idx_t rd_sel,
	output ed_alu_pkg::field_t   x,
	output ed_alu_pkg::field_t   y,
	output ed_alu_pkg::field_t   z,
	output ed_alu_pkg::field_t   t,
	output ed_alu_pkg::field_t   w,
	output ed_alu_pkg::field_t   r,
	output ed_alu_pkg::field_t   rd_data
);
	import ed_alu_pkg::*;

	// Datapath writes win over loads
	always_ff @(posedge clk) begin
		if (rst) begin
			{x, y, z, t, w, r} <= '0;
		end else begin
			if (x_we)
				x <= x_d;
			else if (load_en && load_sel == REG_X)
				x <= load_data;
			if (y_we)
				y <= y_d;
			else if (load_en && load_sel == REG_Y)
				y <= load_data;
			if (z_we)
				z <= z_d;
			else if (load_en && load_sel == REG_Z)
				z <= load_data;
			if (t_we)
				t <= t_d;
			else if (load_en && load_sel == REG_T)
				t <= load_data;
			if (w_we)
				w <= w_d;
			else if (load_en && load_sel == REG_W)
				w <= load_data;
			if (load_en && load_sel == REG_R)
				r <= load_data; // Load only
		end
	end

	always_comb begin
		case (rd_sel)
			REG_X:   rd_data = x;
			REG_Y:   rd_data = y;
			REG_Z:   rd_data = z;
			REG_T:   rd_data = t;
			REG_W:   rd_data = w;
			REG_R:   rd_data = r;
			default: rd_data = '0;
		endcase
	end

endmodule

/* src/ed_alu_top.sv */
`timescale 1ns/1ps

module ed_alu_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 load_en,
	input  ed_alu_pkg::reg_idx_t load_sel,
	input  ed_alu_pkg::field_t   load_data,
	input  logic                 start,
	input  ed_alu_pkg::op_t      op,
	input  logic                 keep,
	input  ed_alu_pkg::reg_idx_t rd_sel,
	output ed_alu_pkg::field_t   rd_data,
	output logic                 busy,
	output logic                 ready
);
	import ed_alu_pkg::*;

	alu_state_t state;
	step_t step;
	logic last;
	field_t mul_a, mul_b, add_a, add_b, sub_a, sub_b;
	field_t mul_res, sum, diff;
	logic x_we, y_we, z_we, t_we, w_we;
	field_t x_d, y_d, z_d, t_d, w_d;
	field_t x, y, z, t, w, r;

	alu_fsm u_fsm (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.op    (op),
		.keep  (keep),
		.last  (last),
		.state (state),
		.busy  (busy),
		.ready (ready)
	);

	step_counter u_step (
		.clk   (clk),
		.rst   (rst),
		.state (state),
		.step  (step),
		.last  (last)
	);

	operand_select u_opsel (
		.state   (state),
		.step    (step),
		.x       (x),
		.y       (y),
		.z       (z),
		.t       (t),
		.w       (w),
		.r       (r),
		.mul_res (mul_res),
		.mul_a   (mul_a),
		.mul_b   (mul_b),
		.add_a   (add_a),
		.add_b   (add_b),
		.sub_a   (sub_a),
		.sub_b   (sub_b)
	);

	field_datapath u_dp (
		.clk     (clk),
		.rst     (rst),
		.mul_a   (mul_a),
		.mul_b   (mul_b),
		.add_a   (add_a),
		.add_b   (add_b),
		.sub_a   (sub_a),
		.sub_b   (sub_b),
		.mul_res (mul_res),
		.sum     (sum),
		.diff    (diff)
	);

	writeback_route u_wb (
		.state   (state),
		.step    (step),
		.mul_res (mul_res),
		.sum     (sum),
		.diff    (diff),
		.w       (w),
		.x_we    (x_we),
		.y_we    (y_we),
		.z_we    (z_we),
		.t_we    (t_we),
		.w_we    (w_we),
		.x_d     (x_d),
		.y_d     (y_d),
		.z_d     (z_d),
		.t_d     (t_d),
		.w_d     (w_d)
	);

	point_regfile u_rf (
		.clk       (clk),
		.rst       (rst),
		.load_en   (load_en),
		.load_sel  (load_sel),
		.load_data (load_data),
		.x_we      (x_we),
		.y_we      (y_we),
		.z_we      (z_we),
		.t_we      (t_we),
		.w_we      (w_we),
		.x_d       (x_d),
		.y_d       (y_d),
		.z_d       (z_d),
		.t_d       (t_d),
		.w_d       (w_d),
		.rd_sel    (rd_sel),
		.x         (x),
		.y         (y),
		.z         (z),
		.t         (t),
		.w         (w),
		.r         (r),
		.rd_data   (rd_data)
	);

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);
	localparam int HALF_PERIOD = 4; // 8 ns period

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule

/* tb/ed_alu_checker.sv */
`timescale 1ns/1ps

module ed_alu_checker (
	input logic clk,
	input logic rst,
	input logic start,
	input logic keep,
	input logic busy,
	input logic ready
);
	int n_ready_idle = 0;
	int n_stays_busy = 0;
	int n_busy_rise = 0;

	ready_in_op: assert property (@(posedge clk) disable iff (rst) ready |-> busy)
	else begin
		$error("ready pulsed while the unit was idle");
		n_ready_idle++;
	end

	// Without keep the unit must drop back to idle
	idle_after_last: assert property (@(posedge clk) disable iff (rst)
		ready && !keep |=> !busy)
	else begin
		$error("busy stayed high after a final ready pulse");
		n_stays_busy++;
	end

	busy_needs_start: assert property (@(posedge clk) disable iff (rst)
		$rose(busy) |-> $past(start))
	else begin
		$error("busy rose without an accepted start");
		n_busy_rise++;
	end

endmodule

/* tb/tb_ed_alu.sv */
`timescale 1ns/1ps

module tb_ed_alu;
	import ed_alu_pkg::*;

	localparam string STIM_FILE = "tb/ed_alu_stim.txt";
	localparam int STEP_BUDGET = 16; // Cycles allowed per operation
	localparam int REP_MAX = 12;
	localparam int DOUBLE_LAT = 11;
	localparam int SCALE_LAT = 3;
	localparam logic [511:0] P_WIDE = {257'd0, P_MODULUS};

	logic clk;
	logic rst;
	logic load_en;
	reg_idx_t load_sel;
	field_t load_data;
	logic start;
	op_t op;
	logic keep;
	reg_idx_t rd_sel;
	field_t rd_data;
	logic busy;
	logic ready;

	string names[$];
	op_t ops[$];
	int reps_q[$];
	field_t wx_q[$];
	field_t wy_q[$];
	field_t wz_q[$];
	field_t wt_q[$];
	field_t wr_q[$];
	string reg_names[6] = '{"X", "Y", "Z", "T", "W", "R"};
	integer seed;
	int errors;
	int tests_failed;
	int chk_fails;
	bit loaded;

	tb_clock u_clk (
		.clk (clk)
	);

	ed_alu_top UUT (
		.clk       (clk),
		.rst       (rst),
		.load_en   (load_en),
		.load_sel  (load_sel),
		.load_data (load_data),
		.start     (start),
		.op        (op),
		.keep      (keep),
		.rd_sel    (rd_sel),
		.rd_data   (rd_data),
		.busy      (busy),
		.ready     (ready)
	);

	bind ed_alu_top ed_alu_checker u_chk (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.keep  (keep),
		.busy  (busy),
		.ready (ready)
	);

	function automatic field_t fmul(field_t a, field_t b);
		logic [511:0] prod;
		prod = {257'd0, a} * {257'd0, b};
		return field_t'(prod % P_WIDE);
	endfunction

	function automatic field_t fadd(field_t a, field_t b);
		logic [511:0] s;
		s = {257'd0, a} + {257'd0, b};
		return field_t'(s % P_WIDE);
	endfunction

	function automatic field_t fsub(field_t a, field_t b);
		logic [511:0] s;
		s = {257'd0, a} + P_WIDE - {257'd0, b}; // Operands are below p
		return field_t'(s % P_WIDE);
	endfunction

	// Odd values map to p minus themselves
	function automatic field_t even_rep(field_t v);
		return v[0] ? fsub('0, v) : v;
	endfunction

	// Words at or above p stand for a random field value
	function automatic field_t word_or_random(field_t v);
		logic [255:0] raw;
		field_t f;
		if (v < P_MODULUS)
			return v;
		for (int k = 0; k < 8; k++)
			raw[32*k +: 32] = $random(seed);
		f = raw[254:0];
		if (f >= P_MODULUS)
			f = f - P_MODULUS;
		return f;
	endfunction

	// Extended-coordinate doubling with a = -1
	task automatic double_point(inout field_t px, inout field_t py, inout field_t pz,
		inout field_t pt);
		field_t a, b, s, g, e, f, xy;
		a = fmul(px, px);
		b = fmul(py, py);
		s = fadd(a, b);
		g = fsub(b, a);
		xy = fadd(px, py);
		e = fsub(fmul(xy, xy), s);
		f = fsub(g, fadd(fmul(pz, pz), fmul(pz, pz)));
		px = fmul(e, f);
		py = fsub('0, fmul(g, s));
		pt = fsub('0, fmul(e, s));
		pz = fmul(f, g);
	endtask

	task automatic read_stim();
		int fd;
		int n;
		string line;
		logic [8*32-1:0] name_v;
		int op_v;
		int rep_v;
		field_t vx, vy, vz, vt, vr;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("ERROR: cannot open stimulus file %0s", STIM_FILE);
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n <= 0 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%s %d %d %h %h %h %h %h", name_v, op_v, rep_v,
				vx, vy, vz, vt, vr);
			if (n != 8)
				continue; // Blank or malformed line
			names.push_back(string'(name_v));
			ops.push_back(op_t'(op_v));
			reps_q.push_back(rep_v);
			wx_q.push_back(vx);
			wy_q.push_back(vy);
			wz_q.push_back(vz);
			wt_q.push_back(vt);
			wr_q.push_back(vr);
		end
		$fclose(fd);
	endtask

	task automatic run_test(input int idx);
		field_t init[6];
		field_t exp[6];
		field_t got[6];
		string tname;
		int reps;
		int lat_exp;
		int cyc;
		int last_cyc;
		int pulses;
		int bad;
		bit done;
		tname = names[idx];
		reps = reps_q[idx];
		bad = 0;
		if (reps < 1 || reps > REP_MAX) begin
			$display("ERROR: %0s has repeat count %0d out of range", tname, reps);
			bad++;
			reps = 1;
		end
		init[REG_X] = word_or_random(wx_q[idx]);
		init[REG_Y] = word_or_random(wy_q[idx]);
		init[REG_Z] = word_or_random(wz_q[idx]);
		init[REG_T] = word_or_random(wt_q[idx]);
		init[REG_W] = '0;
		init[REG_R] = word_or_random(wr_q[idx]);
		exp = init;
		if (ops[idx] == OP_DOUBLE) begin
			for (int k = 0; k < reps; k++)
				double_point(exp[REG_X], exp[REG_Y], exp[REG_Z], exp[REG_T]);
			exp[REG_W] = exp[REG_Y]; // Scratch ends holding -G*S
			lat_exp = DOUBLE_LAT;
		end else begin
			exp[REG_X] = even_rep(fmul(init[REG_X], init[REG_R]));
			exp[REG_Y] = even_rep(fmul(init[REG_Y], init[REG_R]));
			lat_exp = SCALE_LAT;
		end

		for (int k = 0; k < 6; k++) begin
			@(posedge clk);
			load_en <= 1'b1;
			load_sel <= reg_idx_t'(k);
			load_data <= init[k];
		end
		@(posedge clk);
		load_en <= 1'b0;
		start <= 1'b1;
		op <= ops[idx];
		keep <= (ops[idx] == OP_DOUBLE) && (reps > 1);
		@(posedge clk); // Start accepted here
		start <= 1'b0;

		cyc = 0;
		last_cyc = 0;
		pulses = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge clk);
			cyc++;
			if (!busy) begin
				$display("ERROR: %0s busy low before the last ready, cycle %0d", tname, cyc);
				bad++;
				done = 1'b1;
			end else if (ready) begin
				pulses++;
				if (cyc - last_cyc != lat_exp) begin
					$display("FAIL %0s ready %0d latency expected %0d actual %0d",
						tname, pulses, lat_exp, cyc - last_cyc);
					bad++;
				end
				last_cyc = cyc;
				done = (pulses == reps);
			end
			if (!done && cyc >= STEP_BUDGET * reps) begin
				$display("ERROR: %0s saw %0d of %0d ready pulses in %0d cycles",
					tname, pulses, reps, cyc);
				bad++;
				done = 1'b1;
			end
			if (!done) begin
				@(posedge clk);
				start <= (cyc == 1); // Stray start while busy
				if (pulses == reps - 1)
					keep <= 1'b0; // Last doubling of the chain
			end
		end

		for (int k = 0; k < 6; k++) begin
			@(posedge clk);
			keep <= 1'b0;
			rd_sel <= reg_idx_t'(k);
			@(negedge clk);
			got[k] = rd_data;
			if (k == 0 && (busy || ready)) begin
				$display("ERROR: %0s unit still active after its last ready", tname);
				bad++;
			end
		end

		for (int k = 0; k < 6; k++) begin
			if (got[k] !== exp[k]) begin
				$display("FAIL %0s %0s expected %h actual %h",
					tname, reg_names[k], exp[k], got[k]);
				bad++;
			end
		end
		if (ops[idx] == OP_SCALE && (got[REG_X][0] || got[REG_Y][0])) begin
			$display("ERROR: %0s scale left an odd coordinate", tname);
			bad++;
		end

		if (bad == 0) begin
			$display("ok   %0s, %0d ready pulse(s)", tname, pulses);
		end else begin
			$display("bad  %0s, %0d problem(s)", tname, bad);
			tests_failed++;
		end
		errors += bad;
	endtask

	initial begin
		seed = 24;
		errors = 0;
		tests_failed = 0;
		loaded = 1'b0;
		rst <= 1'b1;
		load_en <= 1'b0;
		load_sel <= REG_X;
		load_data <= '0;
		start <= 1'b0;
		op <= OP_DOUBLE;
		keep <= 1'b0;
		rd_sel <= REG_X;
		read_stim();
		loaded = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		if (names.size() == 0) begin
			$display("ERROR: no test vectors were read");
			errors++;
		end
		for (int i = 0; i < names.size(); i++)
			run_test(i);
		chk_fails = UUT.u_chk.n_ready_idle + UUT.u_chk.n_stays_busy + UUT.u_chk.n_busy_rise;
		$display("tests run %0d, tests failed %0d, failed checks %0d, assertion failures %0d",
			names.size(), tests_failed, errors, chk_fails);
		if (errors == 0 && chk_fails == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Budget grows with the number of vectors
	initial begin
		wait (loaded);
		repeat (names.size() * STEP_BUDGET * REP_MAX + 100) @(posedge clk);
		$display("ERROR: watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

endmodule

/* tb/ed_alu_stim.txt */
# name op reps X Y Z T R, words in hex; op 0 doubles reps times with keep, op 1 scales X, Y by R
# a word of 2^255-1 is replaced by a random field value
dbl_base 0 1 216936d3cd6e53fec0a4e231fdd6dc5c692cc7609525a7b2c9562d608f25d51a 6666666666666666666666666666666666666666666666666666666666666658 1 67875f0fd78b766566ea4e8e64abe37d20f09f80775152f56dde8ab3a5b7dda3 2b
dbl_chain3 0 3 216936d3cd6e53fec0a4e231fdd6dc5c692cc7609525a7b2c9562d608f25d51a 6666666666666666666666666666666666666666666666666666666666666658 1 67875f0fd78b766566ea4e8e64abe37d20f09f80775152f56dde8ab3a5b7dda3 2b
dbl_small 0 1 2 3 1 6 0
dbl_rand 0 2 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
scl_rand_a 1 1 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 5 7 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
scl_rand_b 1 1 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
scl_x_zero 1 1 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff 1 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff
scl_r_one 1 1 5 a 1 0 1
scl_neg_one 1 1 3 4 1 0 7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffec

/* flist.f */
src/ed_alu_pkg.sv
src/alu_fsm.sv
src/step_counter.sv
src/operand_select.sv
src/field_datapath.sv
src/writeback_route.sv
src/point_regfile.sv
src/ed_alu_top.sv
tb/tb_clock.sv
tb/ed_alu_checker.sv
tb/tb_ed_alu.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
	--top-module tb_ed_alu -o sim_ed_alu || { echo "build failed"; exit 1; }
out=$(./obj_dir/sim_ed_alu +verilator+error+limit+100)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
